//--- build.f
+incdir+common
common/sd_tx_pkg.sv
common/sd_word_if.sv
common/sd_crc_if.sv
design/sd_tx_crc.sv
design/sd_tx_packetizer.sv
design/sd_tx_serializer.sv
design/sd_tx_frame.sv
dv/sd_tx_frame_tb.sv

//--- dv/sd_tx_frame_tb.sv
/*
 * SD transmit framer testbench
 * Directed frames in 1-wire and 4-wire mode, checked lane word by
 * lane word against a bit-serial CRC-16 model of each lane.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

module sd_tx_frame_tb;
	import sd_tx_pkg::*;

	localparam int BEAT_TIMEOUT  = 400;
	localparam int FRAME_TIMEOUT = 1000;

	logic				i_clk;
	logic				i_reset;
	bus_width_t			i_cfg_width;
	logic				i_en;
	logic				i_ckstb;
	logic				i_s_valid;
	logic [`SD_WORD_W-1:0]		i_s_data;
	logic				i_s_last;
	logic				o_s_ready;
	logic				o_tx_valid;
	logic [`SD_LANE_W-1:0]		o_tx_data;

	logic [`SD_WORD_W-1:0]		words[$];
	logic [`SD_LANE_W-1:0]		seen[$];
	logic [`SD_LANE_W-1:0]		exp_q[$];
	logic [31:0]			rng_state;
	logic				stb_prev = 1'b0;
	int				ready_count;
	int				strobe_div = 3;
	int				strobe_phase = 0;

	sd_tx_frame UUT (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_cfg_width	(i_cfg_width),
		.i_en		(i_en),
		.i_ckstb	(i_ckstb),
		.i_s_valid	(i_s_valid),
		.o_s_ready	(o_s_ready),
		.i_s_data	(i_s_data),
		.i_s_last	(i_s_last),
		.o_tx_valid	(o_tx_valid),
		.o_tx_data	(o_tx_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// Strobe every strobe_div clocks
	always @(negedge i_clk) begin
		if (strobe_phase + 1 >= strobe_div) begin
			strobe_phase = 0;
			i_ckstb = 1'b1;
		end else begin
			strobe_phase++;
			i_ckstb = 1'b0;
		end
	end

	////////////////////
	// Line monitor
	always @(posedge i_clk) begin
		stb_prev <= i_ckstb;
		if (o_s_ready)
			ready_count++;
	end

	// Output settles one clock after a strobe
	always @(negedge i_clk) begin
		if (stb_prev && o_tx_valid)
			seen.push_back(o_tx_data);
	end

	////////////////////
	// Reference model
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic logic [`SD_NCRC-1:0] crc16_step(input logic [`SD_NCRC-1:0] c,
		input logic din);
		logic fb;

		fb = c[`SD_NCRC-1] ^ din;
		c = {c[`SD_NCRC-2:0], 1'b0};
		return fb ? (c ^ `SD_CRC_POLY) : c;
	endfunction

	// Lane n of a 4-wire frame carries bit n of every nibble
	function automatic logic [`SD_NCRC-1:0] lane_crc(input bit four_wire, input int lane);
		logic [`SD_NCRC-1:0] c;

		c = '0;
		foreach (words[i]) begin
			if (four_wire) begin
				for (int nb = 7; nb >= 0; nb--)
					c = crc16_step(c, words[i][nb*4+lane]);
			end else begin
				for (int b = `SD_WORD_W-1; b >= 0; b--)
					c = crc16_step(c, words[i][b]);
			end
		end
		return c;
	endfunction

	task automatic build_expected(input bus_width_t width);
		logic [`SD_NCRC-1:0] c[4];

		exp_q.delete();
		if (width == WIDTH_4W) begin
			exp_q.push_back(8'hF0);
			foreach (words[i])
				for (int nb = 7; nb >= 0; nb--)
					exp_q.push_back({4'hF, words[i][nb*4 +: 4]});
			for (int ln = 0; ln < `SD_LANES; ln++)
				c[ln] = lane_crc(1'b1, ln);
			for (int bp = `SD_NCRC-1; bp >= 0; bp--)
				exp_q.push_back({4'hF, c[3][bp], c[2][bp], c[1][bp], c[0][bp]});
		end else begin
			exp_q.push_back(8'hFE);
			foreach (words[i])
				for (int b = `SD_WORD_W-1; b >= 0; b--)
					exp_q.push_back({7'h7F, words[i][b]});
			c[0] = lane_crc(1'b0, 0);
			for (int bp = `SD_NCRC-1; bp >= 0; bp--)
				exp_q.push_back({7'h7F, c[0][bp]});
		end
		// Stop bit
		exp_q.push_back(8'hFF);
	endtask

	////////////////////
	// Checks and stimulus
	task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
		input string what);
		assert (got === want) else begin
			$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge i_clk);
			check_equal(o_tx_valid, 1'b0, "o_tx_valid while idle");
			check_equal(o_s_ready, 1'b0, "o_s_ready while idle");
			check_equal(o_tx_data, 8'hFF, "o_tx_data while idle");
		end
	endtask

	task automatic make_words(input int n);
		words.delete();
		repeat (n)
			words.push_back(lcg_next());
	endtask

	// Streams the words; late_width is applied after the first beat
	task automatic run_frame(input bus_width_t width, input bus_width_t late_width);
		int idx;
		int waited;
		bit taken;

		idx = 0;
		waited = 0;
		@(negedge i_clk);
		seen.delete();
		ready_count = 0;
		i_cfg_width = width;
		i_en = 1'b1;
		i_s_valid = 1'b1;
		i_s_data = words[0];
		i_s_last = (words.size() == 1);
		while (idx < words.size()) begin
			@(posedge i_clk);
			taken = o_s_ready && i_s_valid;
			@(negedge i_clk);
			if (taken) begin
				idx++;
				waited = 0;
				if (idx == 1)
					i_cfg_width = late_width;
				if (idx < words.size()) begin
					i_s_data = words[idx];
					i_s_last = (idx == words.size() - 1);
				end else begin
					i_s_valid = 1'b0;
					i_s_last = 1'b0;
					i_en = 1'b0;
					i_s_data = '0;
				end
			end else begin
				waited++;
				if (waited > BEAT_TIMEOUT)
					abort_on_timeout("a stream beat to be taken");
			end
		end
		waited = 0;
		while (o_tx_valid) begin
			@(negedge i_clk);
			waited++;
			if (waited > FRAME_TIMEOUT)
				abort_on_timeout("o_tx_valid to fall at the end of the frame");
		end
	endtask

	task automatic send_and_check(input bus_width_t width, input bus_width_t late_width);
		run_frame(width, late_width);
		build_expected(width);
		check_equal(seen.size(), exp_q.size(), "lane word count");
		foreach (exp_q[i])
			check_equal(seen[i], exp_q[i], $sformatf("lane word %0d", i));
		check_equal(ready_count, words.size(), "o_s_ready pulse count");
		check_idle(4);
	endtask

	////////////////////
	// Directed tests
	task automatic idle_after_reset();
		check_idle(8);
	endtask

	task automatic one_wire_frame();
		make_words(3);
		send_and_check(WIDTH_1W, WIDTH_1W);
	endtask

	task automatic four_wire_frame();
		make_words(4);
		send_and_check(WIDTH_4W, WIDTH_4W);
	endtask

	// Same words at both strobe rates must give the same expected sequence
	task automatic strobe_spacing();
		make_words(4);
		send_and_check(WIDTH_4W, WIDTH_4W);
		strobe_div = 5;
		send_and_check(WIDTH_4W, WIDTH_4W);
		strobe_div = 3;
	endtask

	// Width held for the frame, new width taken by the next one
	task automatic width_switch_mid_frame();
		make_words(3);
		send_and_check(WIDTH_1W, WIDTH_4W);
		make_words(4);
		send_and_check(WIDTH_4W, WIDTH_1W);
		make_words(2);
		send_and_check(WIDTH_1W, WIDTH_1W);
	endtask

	initial begin
		i_reset = 1'b0;
		i_cfg_width = WIDTH_1W;
		i_en = 1'b0;
		i_ckstb = 1'b0;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_last = 1'b0;
		rng_state = 32'd3;
		repeat (3) @(negedge i_clk);
		i_reset = 1'b1;

		idle_after_reset();
		one_wire_frame();
		four_wire_frame();
		strobe_spacing();
		width_switch_mid_frame();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- design/sd_tx_frame.sv
/*
 * SD data line transmit framer
 * Takes a word stream and sends one block per frame: start bit,
 * data MSB first, one CRC-16 per lane and a stop bit. One lane word
 * goes out per clock strobe, in 1-wire or 4-wire mode.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

module sd_tx_frame (
	input	logic				i_clk,
	input	logic				i_reset,
	input	sd_tx_pkg::bus_width_t		i_cfg_width,
	input	logic				i_en,
	input	logic				i_ckstb,
	// Word stream from memory
	input	logic				i_s_valid,
	output	logic				o_s_ready,
	input	logic [`SD_WORD_W-1:0]		i_s_data,
	input	logic				i_s_last,
	// Lane output
	output	logic				o_tx_valid,
	output	logic [`SD_LANE_W-1:0]		o_tx_data
);

	sd_word_if	word_bus ();
	sd_crc_if	crc_bus ();

	logic		start;

	// Ready in idle already implies enable, strobe and an empty serializer
	assign start = i_s_valid && o_s_ready && !o_tx_valid;

	sd_tx_packetizer u_packetizer (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_cfg_width	(i_cfg_width),
		.i_en		(i_en),
		.i_ckstb	(i_ckstb),
		.i_s_valid	(i_s_valid),
		.i_s_data	(i_s_data),
		.i_s_last	(i_s_last),
		.i_tx_valid	(o_tx_valid),
		.o_s_ready	(o_s_ready),
		.word		(word_bus.src),
		.crc		(crc_bus.ctl)
	);

	sd_tx_crc u_crc (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.crc		(crc_bus.bank)
	);

	// Width seen by the serializer is the one the packetizer holds
	sd_tx_serializer u_serializer (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_ckstb	(i_ckstb),
		.i_cfg_width	(crc_bus.width),
		.i_start	(start),
		.word		(word_bus.dst),
		.o_tx_valid	(o_tx_valid),
		.o_tx_data	(o_tx_data)
	);

endmodule

//--- design/sd_tx_serializer.sv
/*
 * Lane serializer
 * Sends the start bit, then shifts each word out MSB first, one
 * lane word per strobe, and closes the frame with a stop bit.
 * Unused lanes stay at one.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

module sd_tx_serializer (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_ckstb,
	input	sd_tx_pkg::bus_width_t		i_cfg_width,
	input	logic				i_start,
	sd_word_if.dst				word,
	output	logic				o_tx_valid,
	output	sd_tx_pkg::lane_word_t		o_tx_data
);
	import sd_tx_pkg::*;

	logic				stop_bit;
	logic [`SD_WORD_W-1:0]		sreg;
	logic [`SD_WORD_W-1:0]		load_sreg;
	logic [`SD_WORD_W-1:0]		shift_sreg;
	logic [4:0]			count;
	logic [4:0]			load_count;
	logic				empty;
	lane_word_t			start_lane;
	lane_word_t			load_lane;
	lane_word_t			shift_lane;

	assign empty           = (count == 5'd0);
	assign word.word_ready = i_ckstb && empty;

	////////////////////
	// Lane words and shift values per width
	always_comb begin
		start_lane = '1;
		load_lane  = '1;
		shift_lane = '1;
		if (i_cfg_width == WIDTH_4W) begin
			start_lane.w4.dat = '0;
			load_lane.w4.dat  = word.word_data[`SD_WORD_W-1 -: `SD_LANES];
			shift_lane.w4.dat = sreg[`SD_WORD_W-1 -: `SD_LANES];
			load_sreg  = {word.word_data[`SD_WORD_W-`SD_LANES-1:0], {`SD_LANES{1'b1}}};
			shift_sreg = {sreg[`SD_WORD_W-`SD_LANES-1:0], {`SD_LANES{1'b1}}};
			load_count = 5'(`SD_CNT_4W);
		end else begin
			start_lane.w1.dat0 = 1'b0;
			load_lane.w1.dat0  = word.word_data[`SD_WORD_W-1];
			shift_lane.w1.dat0 = sreg[`SD_WORD_W-1];
			load_sreg  = {word.word_data[`SD_WORD_W-2:0], 1'b1};
			shift_sreg = {sreg[`SD_WORD_W-2:0], 1'b1};
			// Short CRC word stops after 16 bits
			load_count = word.word_short ? 5'(`SD_CNT_1W_CRC) : 5'(`SD_CNT_1W);
		end
	end

	////////////////////
	// Output and count control
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			o_tx_valid <= 1'b0;
			stop_bit   <= 1'b0;
			count      <= 5'd0;
			o_tx_data  <= '1;
		end else if (i_start) begin
			o_tx_valid <= 1'b1;
			stop_bit   <= 1'b1;
			o_tx_data  <= start_lane;
		end else if (word.word_ready) begin
			// Empty strobe with no word is the stop bit, then the end
			o_tx_valid <= word.word_valid || stop_bit;
			stop_bit   <= word.word_valid;
			if (word.word_valid) begin
				o_tx_data <= load_lane;
				count     <= load_count;
			end else begin
				o_tx_data <= '1;
			end
		end else if (i_ckstb && !empty) begin
			count     <= count - 5'd1;
			o_tx_data <= shift_lane;
		end
	end

	always_ff @(posedge i_clk) begin
		if (word.word_ready && word.word_valid)
			sreg <= load_sreg;
		else if (i_ckstb && !empty)
			sreg <= shift_sreg;
	end

endmodule

//--- design/sd_tx_packetizer.sv
/*
 * Frame packetizer
 * Runs the IDLE/DATA/CRC/LAST sequence, holds the bus width for the
 * length of a frame and passes data words, then CRC words, to the
 * serializer one at a time.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

module sd_tx_packetizer (
	input	logic				i_clk,
	input	logic				i_reset,
	input	sd_tx_pkg::bus_width_t		i_cfg_width,
	input	logic				i_en,
	input	logic				i_ckstb,
	input	logic				i_s_valid,
	input	logic [`SD_WORD_W-1:0]		i_s_data,
	input	logic				i_s_last,
	input	logic				i_tx_valid,
	output	logic				o_s_ready,
	sd_word_if.src				word,
	sd_crc_if.ctl				crc
);
	import sd_tx_pkg::*;

	frame_state_t	state;
	bus_width_t	cfg_width;
	bus_width_t	width;
	logic [1:0]	crc_cnt;
	logic		accept;
	logic		word_xfer;

	////////////////////
	// Configuration
	// Idle follows the input so the start bit already uses it
	assign width = (state != IDLE) ? cfg_width
		: (i_cfg_width == WIDTH_4W) ? WIDTH_4W : WIDTH_1W;

	always_ff @(posedge i_clk) begin
		if (!i_reset)
			cfg_width <= WIDTH_1W;
		else if (state == IDLE)
			cfg_width <= width;
	end

	////////////////////
	// Handshakes
	assign o_s_ready = word.word_ready && (state == DATA
		|| (state == IDLE && i_en && i_ckstb && !i_tx_valid));
	assign accept    = i_s_valid && o_s_ready;
	assign word_xfer = word.word_valid && word.word_ready;

	////////////////////
	// Frame FSM
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			state           <= IDLE;
			word.word_valid <= 1'b0;
			word.word_short <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				word.word_valid <= 1'b0;
				word.word_short <= 1'b0;
				if (accept) begin
					state           <= i_s_last ? CRC : DATA;
					word.word_valid <= 1'b1;
				end
			end
			DATA: begin
				if (accept && i_s_last)
					state <= CRC;
			end
			CRC: begin
				if (word_xfer) begin
					// Single CRC word is the short one
					word.word_short <= (width == WIDTH_1W);
					if (crc_cnt == 2'd0)
						state <= LAST;
				end
			end
			LAST: begin
				if (word_xfer) begin
					word.word_valid <= 1'b0;
					word.word_short <= 1'b0;
				end
				// Stop bit has gone out
				if (!i_tx_valid)
					state <= IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept)
			word.word_data <= i_s_data;
		else if (state == CRC && word_xfer)
			word.word_data <= crc.crc_word;
	end

	// CRC words still to follow the current one
	always_ff @(posedge i_clk) begin
		if (!i_reset)
			crc_cnt <= 2'd0;
		else if (state == IDLE || state == DATA)
			crc_cnt <= (width == WIDTH_4W) ? 2'(`SD_CRC_WORDS_4W - 1) : 2'd0;
		else if (crc.shift && crc_cnt != 2'd0)
			crc_cnt <= crc_cnt - 2'd1;
	end

	assign crc.accept = accept;
	assign crc.data   = i_s_data;
	assign crc.shift  = (state == CRC) && word_xfer;
	// Fresh CRC before the next frame
	assign crc.clear  = (state == IDLE && !i_en) || (state == LAST && !i_tx_valid);
	assign crc.width  = width;

endmodule

//--- design/sd_tx_crc.sv
/*
 * Per-lane CRC-16 bank
 * One register for 1-wire mode, four lane-interleaved registers for
 * 4-wire mode. Advances on each stream beat and shifts out one
 * 32-bit CRC word at a time.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

module sd_tx_crc (
	input	logic		i_clk,
	input	logic		i_reset,
	sd_crc_if.bank		crc
);
	import sd_tx_pkg::*;

	localparam int CRC4_W = `SD_NCRC * `SD_LANES;

	logic [`SD_NCRC-1:0]	crc_1w;
	logic [`SD_NCRC-1:0]	crc_1w_next;
	// Bit k of lane n sits at k*4+n, so each nibble is one bit position
	logic [CRC4_W-1:0]	crc_4w;
	logic [CRC4_W-1:0]	crc_4w_next;

	function automatic logic [`SD_NCRC-1:0] crc_step(
		input logic [`SD_NCRC-1:0]	prior,
		input logic			din
	);
		logic [`SD_NCRC-1:0] shifted;

		shifted = {prior[`SD_NCRC-2:0], 1'b0};
		if (prior[`SD_NCRC-1] ^ din)
			return shifted ^ `SD_CRC_POLY;
		return shifted;
	endfunction

	////////////////////
	// Next CRC values
	always_comb begin : advance
		logic [`SD_NCRC-1:0] lane_crc;

		// Whole word through one lane, MSB first
		crc_1w_next = crc_1w;
		for (int b = 0; b < `SD_WORD_W; b++)
			crc_1w_next = crc_step(crc_1w_next, crc.data[`SD_WORD_W-1-b]);

		// Lane n takes bit n of each nibble
		crc_4w_next = crc_4w;
		for (int ln = 0; ln < `SD_LANES; ln++) begin
			for (int k = 0; k < `SD_NCRC; k++)
				lane_crc[k] = crc_4w[k*`SD_LANES+ln];
			for (int b = 0; b < `SD_WORD_W/`SD_LANES; b++)
				lane_crc = crc_step(lane_crc,
					crc.data[`SD_WORD_W-`SD_LANES-`SD_LANES*b+ln]);
			for (int k = 0; k < `SD_NCRC; k++)
				crc_4w_next[k*`SD_LANES+ln] = lane_crc[k];
		end
	end

	////////////////////
	// Registers
	always_ff @(posedge i_clk) begin
		if (!i_reset || crc.clear) begin
			crc_1w <= '0;
			crc_4w <= '0;
		end else if (crc.accept) begin
			if (crc.width == WIDTH_4W)
				crc_4w <= crc_4w_next;
			else
				crc_1w <= crc_1w_next;
		end else if (crc.shift) begin
			crc_1w <= '1;
			// Next word moves up, ones fill behind
			crc_4w <= {crc_4w[CRC4_W-`SD_WORD_W-1:0], {`SD_WORD_W{1'b1}}};
		end
	end

	// 1-wire CRC rides in the top half, bottom half never sent
	assign crc.crc_word = (crc.width == WIDTH_4W)
		? crc_4w[CRC4_W-1 -: `SD_WORD_W]
		: {crc_1w, {(`SD_WORD_W-`SD_NCRC){1'b1}}};

endmodule

//--- common/sd_crc_if.sv
/*
 * CRC bank control channel
 * Packetizer tells the CRC bank when a beat is taken and when a CRC
 * word leaves; the bank returns the next CRC word to send.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

interface sd_crc_if;
	import sd_tx_pkg::*;

	logic				accept;
	logic [`SD_WORD_W-1:0]		data;
	logic				shift;
	logic				clear;
	bus_width_t			width;
	logic [`SD_WORD_W-1:0]		crc_word;

	modport ctl (
		output	accept,
		output	data,
		output	shift,
		output	clear,
		output	width,
		input	crc_word
	);

	modport bank (
		input	accept,
		input	data,
		input	shift,
		input	clear,
		input	width,
		output	crc_word
	);

endinterface

//--- common/sd_word_if.sv
/*
 * Formatted word channel
 * Carries data and CRC words from the packetizer to the serializer.
 * A word moves when valid and ready are both high.
 */
`timescale 1ns/1ps
`include "sd_tx_consts.svh"

interface sd_word_if;

	logic				word_valid;
	logic				word_ready;
	logic [`SD_WORD_W-1:0]		word_data;
	// Short CRC word, only 16 bits go out in 1-wire mode
	logic				word_short;

	modport src (
		output	word_valid,
		output	word_data,
		output	word_short,
		input	word_ready
	);

	modport dst (
		input	word_valid,
		input	word_data,
		input	word_short,
		output	word_ready
	);

endinterface

//--- common/sd_tx_pkg.sv
/*
 * SD transmit framer types
 * Bus width and frame state encodings, plus the output lane word
 * with its 1-wire and 4-wire views.
 */
`include "sd_tx_consts.svh"

package sd_tx_pkg;

	// Codes 2 and 3 fall back to 1-wire
	typedef enum logic [1:0] {
		WIDTH_1W = 2'b00,
		WIDTH_4W = 2'b01
	} bus_width_t;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		DATA = 2'b01,
		CRC  = 2'b10,
		LAST = 2'b11
	} frame_state_t;

	////////////////////
	// Output lane word views
	typedef struct packed {
		logic [`SD_LANE_W-2:0]		pad;
		logic				dat0;
	} lane_w1_t;

	typedef struct packed {
		logic [`SD_LANE_W-`SD_LANES-1:0]	pad;
		logic [`SD_LANES-1:0]		dat;
	} lane_w4_t;

	typedef union packed {
		lane_w1_t	w1;
		lane_w4_t	w4;
	} lane_word_t;

endpackage

//--- common/sd_tx_consts.svh
/*
 * SD transmit framer constants
 * Word and lane widths, CRC parameters and the shift counts that the
 * serializer reloads for each word it takes.
 */
`ifndef SD_TX_CONSTS_SVH
`define SD_TX_CONSTS_SVH

// Stream and lane widths
`define SD_WORD_W		32
`define SD_LANES		4
`define SD_LANE_W		8

// CRC-16, polynomial x^16 + x^12 + x^5 + 1
`define SD_NCRC			16
`define SD_CRC_POLY		16'h1021

////////////////////
// Strobes left after a word is loaded
`define SD_CNT_1W		31
`define SD_CNT_1W_CRC		15
`define SD_CNT_4W		7

// Two 32-bit words carry four 16-bit CRCs
`define SD_CRC_WORDS_4W		2

`endif
